/* hw/chip_params.svh */
// Chip subsystem parameters
// Widths, FIFO depth, IDCODE, APB page map and register offsets

`ifndef CHIP_PARAMS_SVH
`define CHIP_PARAMS_SVH

`define CHIP_GPIO_WIDTH      16
`define CHIP_SPI_RX_DEPTH    4
`define CHIP_JTAG_IDCODE     32'h1A5C_3E2D

// APB pages, decoded from address bits 11:8
`define CHIP_APB_SEL_GPIO    4'h0
`define CHIP_APB_SEL_SPI     4'h1

// Register offsets within a page
`define CHIP_GPIO_OUT_OFS    8'h00
`define CHIP_GPIO_OE_OFS     8'h04
`define CHIP_GPIO_IN_OFS     8'h08
`define CHIP_SPI_RXDATA_OFS  8'h00
`define CHIP_SPI_STATUS_OFS  8'h04
`define CHIP_SPI_TXDATA_OFS  8'h08

`endif

/* hw/chip_pkg.sv */
// Chip subsystem package
// Bus, GPIO, SPI and JTAG types shared by the blocks

`default_nettype none

`include "chip_params.svh"

package chip_pkg;

  typedef logic [11:0]                 apb_addr_t;
  typedef logic [31:0]                 apb_data_t;
  typedef logic [`CHIP_GPIO_WIDTH-1:0] gpio_t;
  typedef logic [7:0]                  spi_byte_t;
  typedef logic [3:0]                  jtag_ir_t;

  // Instruction codes
  localparam jtag_ir_t IR_IDCODE = 4'h1;
  localparam jtag_ir_t IR_BYPASS = 4'hF;

  // IEEE 1149.1 controller states
  typedef enum logic [3:0] {
    TAP_TLR,
    TAP_RTI,
    TAP_SEL_DR,
    TAP_CAP_DR,
    TAP_SHIFT_DR,
    TAP_EXIT1_DR,
    TAP_PAUSE_DR,
    TAP_EXIT2_DR,
    TAP_UPD_DR,
    TAP_SEL_IR,
    TAP_CAP_IR,
    TAP_SHIFT_IR,
    TAP_EXIT1_IR,
    TAP_PAUSE_IR,
    TAP_EXIT2_IR,
    TAP_UPD_IR
  } tap_state_e;

endpackage

`default_nettype wire

/* hw/apb_xbar.sv */
// APB crossbar
// Decodes the page to GPIO or SPI, muxes read data, flags unmapped pages

`default_nettype none

`include "chip_params.svh"

module apb_xbar (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  chip_pkg::apb_addr_t paddr_i,
  input  chip_pkg::apb_data_t gpio_rdata_i,
  input  chip_pkg::apb_data_t spi_rdata_i,
  output logic                gpio_sel_o,
  output logic                spi_sel_o,
  output chip_pkg::apb_data_t prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  logic [3:0] page;
  logic       gpio_hit;
  logic       spi_hit;
  logic       setup;
  logic       pready_q;
  logic       pslverr_q;

  assign page     = paddr_i[11:8];
  assign gpio_hit = (page == `CHIP_APB_SEL_GPIO);
  assign spi_hit  = (page == `CHIP_APB_SEL_SPI);
  assign setup    = psel_i & ~penable_i;

  assign gpio_sel_o = psel_i & gpio_hit;
  assign spi_sel_o  = psel_i & spi_hit;

  // Response flags are set up one cycle ahead, so they sit in the access cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= setup;
      pslverr_q <= setup & ~(gpio_hit | spi_hit);
    end
  end

  assign pready_o  = pready_q;
  assign pslverr_o = pslverr_q;

  // Unmapped pages read zero
  always_comb begin
    prdata_o = '0;
    if (psel_i && penable_i) begin
      if (gpio_hit) begin
        prdata_o = gpio_rdata_i;
      end else if (spi_hit) begin
        prdata_o = spi_rdata_i;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/gpio.sv */
// GPIO block
// OUT and OE registers plus a two-flop synchronized IN register on APB

`default_nettype none

`include "chip_params.svh"

module gpio (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  chip_pkg::apb_addr_t addr_i,
  input  chip_pkg::apb_data_t wdata_i,
  input  chip_pkg::gpio_t     gpio_i,
  output chip_pkg::apb_data_t rdata_o,
  output chip_pkg::gpio_t     gpio_o,
  output chip_pkg::gpio_t     gpio_oe_o
);

  chip_pkg::gpio_t out_q;
  chip_pkg::gpio_t oe_q;
  chip_pkg::gpio_t in_meta_q;
  chip_pkg::gpio_t in_q;
  logic            wr_en;

  assign wr_en = sel_i & penable_i & pwrite_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (wr_en) begin
      if (addr_i[7:0] == `CHIP_GPIO_OUT_OFS) begin
        out_q <= wdata_i[`CHIP_GPIO_WIDTH-1:0];
      end
      if (addr_i[7:0] == `CHIP_GPIO_OE_OFS) begin
        oe_q <= wdata_i[`CHIP_GPIO_WIDTH-1:0];
      end
    end
  end

  // Input synchronizer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_q      <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_q      <= in_meta_q;
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

  always_comb begin
    case (addr_i[7:0])
      `CHIP_GPIO_OUT_OFS: rdata_o = chip_pkg::apb_data_t'(out_q);
      `CHIP_GPIO_OE_OFS:  rdata_o = chip_pkg::apb_data_t'(oe_q);
      `CHIP_GPIO_IN_OFS:  rdata_o = chip_pkg::apb_data_t'(in_q);
      default:            rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/spi_device.sv */
// SPI device, mode 0 target
// Oversampled pins, RX FIFO with sticky overflow, TX byte shifted MSB first

`default_nettype none

`include "chip_params.svh"

module spi_device #(
  parameter int RX_DEPTH = `CHIP_SPI_RX_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  chip_pkg::apb_addr_t addr_i,
  input  chip_pkg::apb_data_t wdata_i,
  input  logic                sck_i,
  input  logic                csb_i,
  input  logic                sdi_i,
  output chip_pkg::apb_data_t rdata_o,
  output logic                sdo_o
);

  localparam int PTR_W = $clog2(RX_DEPTH);
  localparam int CNT_W = $clog2(RX_DEPTH + 1);

  logic [2:0]          sck_q;
  logic [2:0]          csb_q;
  logic [1:0]          sdi_q;
  logic                sck_rise;
  logic                sck_fall;
  logic                csb_fall;
  logic                csb_act;
  logic [2:0]          bit_cnt_q;
  logic [6:0]          rx_sr_q;
  logic                byte_done;
  chip_pkg::spi_byte_t rx_byte;
  chip_pkg::spi_byte_t rx_mem [RX_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                full;
  logic                empty;
  logic                push;
  logic                pop;
  logic                ovf_q;
  chip_pkg::spi_byte_t tx_q;
  chip_pkg::spi_byte_t tx_sr_q;
  logic                wr_en;
  logic                rd_en;

  // Two sync flops plus one more for edge detection
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q <= 3'b000;
      csb_q <= 3'b111;
      sdi_q <= 2'b00;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      csb_q <= {csb_q[1:0], csb_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  assign csb_act  = ~csb_q[1];
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign csb_fall = ~csb_q[1] & csb_q[2];

  // Receive shifter, a partial byte is lost when CSB goes high
  assign byte_done = csb_act & sck_rise & (bit_cnt_q == 3'd7);
  assign rx_byte   = {rx_sr_q, sdi_q[1]};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
    end else if (!csb_act) begin
      bit_cnt_q <= '0;
    end else if (sck_rise) begin
      bit_cnt_q <= bit_cnt_q + 3'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csb_act && sck_rise) begin
      rx_sr_q <= rx_byte[6:0];
    end
  end

  // RX FIFO
  assign wr_en = sel_i & penable_i & pwrite_i;
  assign rd_en = sel_i & penable_i & ~pwrite_i;
  assign full  = (count_q == CNT_W'(RX_DEPTH));
  assign empty = (count_q == '0);
  assign push  = byte_done & ~full;
  assign pop   = rd_en & (addr_i[7:0] == `CHIP_SPI_RXDATA_OFS) & ~empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      rx_mem[wr_ptr_q] <= rx_byte;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
      // Set wins over a clear in the same cycle
      if (byte_done && full) begin
        ovf_q <= 1'b1;
      end else if (wr_en && addr_i[7:0] == `CHIP_SPI_STATUS_OFS && wdata_i[8]) begin
        ovf_q <= 1'b0;
      end
    end
  end

  // TX byte and its shifter, loaded on CSB fall
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_q    <= '0;
      tx_sr_q <= '0;
    end else begin
      if (wr_en && addr_i[7:0] == `CHIP_SPI_TXDATA_OFS) begin
        tx_q <= wdata_i[7:0];
      end
      if (csb_fall) begin
        tx_sr_q <= tx_q;
      end else if (csb_act && sck_fall) begin
        tx_sr_q <= {tx_sr_q[6:0], 1'b0};
      end
    end
  end

  assign sdo_o = tx_sr_q[7];

  always_comb begin
    rdata_o = '0;
    case (addr_i[7:0])
      `CHIP_SPI_RXDATA_OFS: begin
        if (!empty) begin
          rdata_o[7:0] = rx_mem[rd_ptr_q];
        end
      end
      `CHIP_SPI_STATUS_OFS: begin
        rdata_o[3:0] = 4'(count_q);
        rdata_o[8]   = ovf_q;
      end
      `CHIP_SPI_TXDATA_OFS: rdata_o[7:0] = tx_q;
      default:              rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/jtag_tap.sv */
// JTAG TAP controller
// 16-state 1149.1 machine with a 4-bit IR, IDCODE and BYPASS registers
// TCK is oversampled on clk_i

`default_nettype none

`include "chip_params.svh"

module jtag_tap (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tck_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o
);

  logic [2:0]           tck_q;
  logic [1:0]           tms_q;
  logic [1:0]           tdi_q;
  logic [1:0]           trst_q;
  logic                 tck_rise;
  logic                 tck_fall;
  logic                 tms_s;
  logic                 tdi_s;
  chip_pkg::tap_state_e state_q;
  chip_pkg::tap_state_e state_d;
  chip_pkg::jtag_ir_t   ir_q;
  chip_pkg::jtag_ir_t   ir_sr_q;
  logic [31:0]          dr_sr_q;
  logic                 idcode_sel;
  logic                 tdo_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tck_q  <= 3'b000;
      tms_q  <= 2'b11;
      tdi_q  <= 2'b00;
      trst_q <= 2'b00;
    end else begin
      tck_q  <= {tck_q[1:0], tck_i};
      tms_q  <= {tms_q[0], tms_i};
      tdi_q  <= {tdi_q[0], tdi_i};
      trst_q <= {trst_q[0], trst_n_i};
    end
  end

  assign tck_rise = tck_q[1] & ~tck_q[2];
  assign tck_fall = ~tck_q[1] & tck_q[2];
  assign tms_s    = tms_q[1];
  assign tdi_s    = tdi_q[1];

  always_comb begin
    case (state_q)
      chip_pkg::TAP_TLR:      state_d = tms_s ? chip_pkg::TAP_TLR      : chip_pkg::TAP_RTI;
      chip_pkg::TAP_RTI:      state_d = tms_s ? chip_pkg::TAP_SEL_DR   : chip_pkg::TAP_RTI;
      chip_pkg::TAP_SEL_DR:   state_d = tms_s ? chip_pkg::TAP_SEL_IR   : chip_pkg::TAP_CAP_DR;
      chip_pkg::TAP_CAP_DR:   state_d = tms_s ? chip_pkg::TAP_EXIT1_DR : chip_pkg::TAP_SHIFT_DR;
      chip_pkg::TAP_SHIFT_DR: state_d = tms_s ? chip_pkg::TAP_EXIT1_DR : chip_pkg::TAP_SHIFT_DR;
      chip_pkg::TAP_EXIT1_DR: state_d = tms_s ? chip_pkg::TAP_UPD_DR   : chip_pkg::TAP_PAUSE_DR;
      chip_pkg::TAP_PAUSE_DR: state_d = tms_s ? chip_pkg::TAP_EXIT2_DR : chip_pkg::TAP_PAUSE_DR;
      chip_pkg::TAP_EXIT2_DR: state_d = tms_s ? chip_pkg::TAP_UPD_DR   : chip_pkg::TAP_SHIFT_DR;
      chip_pkg::TAP_UPD_DR:   state_d = tms_s ? chip_pkg::TAP_SEL_DR   : chip_pkg::TAP_RTI;
      chip_pkg::TAP_SEL_IR:   state_d = tms_s ? chip_pkg::TAP_TLR      : chip_pkg::TAP_CAP_IR;
      chip_pkg::TAP_CAP_IR:   state_d = tms_s ? chip_pkg::TAP_EXIT1_IR : chip_pkg::TAP_SHIFT_IR;
      chip_pkg::TAP_SHIFT_IR: state_d = tms_s ? chip_pkg::TAP_EXIT1_IR : chip_pkg::TAP_SHIFT_IR;
      chip_pkg::TAP_EXIT1_IR: state_d = tms_s ? chip_pkg::TAP_UPD_IR   : chip_pkg::TAP_PAUSE_IR;
      chip_pkg::TAP_PAUSE_IR: state_d = tms_s ? chip_pkg::TAP_EXIT2_IR : chip_pkg::TAP_PAUSE_IR;
      chip_pkg::TAP_EXIT2_IR: state_d = tms_s ? chip_pkg::TAP_UPD_IR   : chip_pkg::TAP_SHIFT_IR;
      chip_pkg::TAP_UPD_IR:   state_d = tms_s ? chip_pkg::TAP_SEL_DR   : chip_pkg::TAP_RTI;
      default:                state_d = chip_pkg::TAP_TLR;
    endcase
  end

  // State and committed IR, TRST wins over TCK
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= chip_pkg::TAP_TLR;
      ir_q    <= chip_pkg::IR_IDCODE;
    end else if (!trst_q[1]) begin
      state_q <= chip_pkg::TAP_TLR;
      ir_q    <= chip_pkg::IR_IDCODE;
    end else if (tck_rise) begin
      state_q <= state_d;
      if (state_d == chip_pkg::TAP_TLR) begin
        ir_q <= chip_pkg::IR_IDCODE;
      end else if (state_q == chip_pkg::TAP_UPD_IR) begin
        ir_q <= ir_sr_q;
      end
    end
  end

  // Unknown codes fall back to bypass
  always_comb begin
    case (ir_q)
      chip_pkg::IR_IDCODE: idcode_sel = 1'b1;
      chip_pkg::IR_BYPASS: idcode_sel = 1'b0;
      default:             idcode_sel = 1'b0;
    endcase
  end

  // Capture and shift, LSB first
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        chip_pkg::TAP_CAP_IR:   ir_sr_q <= 4'b0001;
        chip_pkg::TAP_SHIFT_IR: ir_sr_q <= {tdi_s, ir_sr_q[3:1]};
        chip_pkg::TAP_CAP_DR:   dr_sr_q <= idcode_sel ? `CHIP_JTAG_IDCODE : 32'd0;
        chip_pkg::TAP_SHIFT_DR: begin
          if (idcode_sel) begin
            dr_sr_q <= {tdi_s, dr_sr_q[31:1]};
          end else begin
            dr_sr_q <= {31'd0, tdi_s};
          end
        end
        default: begin
        end
      endcase
    end
  end

  // TDO moves on the falling edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tdo_q <= 1'b0;
    end else if (tck_fall) begin
      if (state_q == chip_pkg::TAP_SHIFT_IR) begin
        tdo_q <= ir_sr_q[0];
      end else if (state_q == chip_pkg::TAP_SHIFT_DR) begin
        tdo_q <= dr_sr_q[0];
      end else begin
        tdo_q <= 1'b0;
      end
    end
  end

  assign tdo_o = tdo_q;

endmodule

`default_nettype wire

/* hw/chip_top.sv */
// Chip top
// APB host port to GPIO and SPI device, strap-selected JTAG or SPI on the debug port

`default_nettype none

module chip_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // APB host port
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  chip_pkg::apb_addr_t paddr_i,
  input  chip_pkg::apb_data_t pwdata_i,
  output chip_pkg::apb_data_t prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // Strap and debug-port pins
  input  logic                jtag_spi_n_i,
  input  logic                dps_sck_i,
  input  logic                dps_sdi_i,
  input  logic                dps_cs_i,
  input  logic                dps_trst_n_i,
  output logic                dps_sdo_o,
  // GPIO
  input  chip_pkg::gpio_t     gpio_i,
  output chip_pkg::gpio_t     gpio_o,
  output chip_pkg::gpio_t     gpio_oe_o
);

  logic                gpio_sel;
  logic                spi_sel;
  chip_pkg::apb_data_t gpio_rdata;
  chip_pkg::apb_data_t spi_rdata;
  logic                spi_sck;
  logic                spi_csb;
  logic                spi_sdi;
  logic                spi_sdo;
  logic                tap_tck;
  logic                tap_tms;
  logic                tap_tdi;
  logic                tap_trst_n;
  logic                tap_tdo;

  // Pin mux, the unselected block sees idle levels
  assign tap_tck    = jtag_spi_n_i ? dps_sck_i    : 1'b0;
  assign tap_tdi    = jtag_spi_n_i ? dps_sdi_i    : 1'b0;
  assign tap_tms    = jtag_spi_n_i ? dps_cs_i     : 1'b1;
  assign tap_trst_n = jtag_spi_n_i ? dps_trst_n_i : 1'b0;
  assign spi_sck    = jtag_spi_n_i ? 1'b0         : dps_sck_i;
  assign spi_sdi    = jtag_spi_n_i ? 1'b0         : dps_sdi_i;
  assign spi_csb    = jtag_spi_n_i ? 1'b1         : dps_cs_i;
  assign dps_sdo_o  = jtag_spi_n_i ? tap_tdo      : spi_sdo;

  apb_xbar u_apb_xbar (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .paddr_i      (paddr_i),
    .gpio_rdata_i (gpio_rdata),
    .spi_rdata_i  (spi_rdata),
    .gpio_sel_o   (gpio_sel),
    .spi_sel_o    (spi_sel),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

  gpio u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .sel_i     (gpio_sel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .addr_i    (paddr_i),
    .wdata_i   (pwdata_i),
    .gpio_i    (gpio_i),
    .rdata_o   (gpio_rdata),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  spi_device u_spi_device (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .sel_i     (spi_sel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .addr_i    (paddr_i),
    .wdata_i   (pwdata_i),
    .sck_i     (spi_sck),
    .csb_i     (spi_csb),
    .sdi_i     (spi_sdi),
    .rdata_o   (spi_rdata),
    .sdo_o     (spi_sdo)
  );

  jtag_tap u_jtag_tap (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .tck_i    (tap_tck),
    .tms_i    (tap_tms),
    .tdi_i    (tap_tdi),
    .trst_n_i (tap_trst_n),
    .tdo_o    (tap_tdo)
  );

endmodule

`default_nettype wire

/* verification/clk_rst_gen.sv */
// Testbench clock and reset generator
// Clock period of 4, reset held low for the first 8 rising edges

`default_nettype none

module clk_rst_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/tb.sv */
// Chip subsystem testbench
// Drives the APB port, GPIO pins and the shared debug port as SPI or JTAG
// and compares against register images, a byte queue and the IDCODE

`default_nettype none

`include "chip_params.svh"

module tb;

  localparam int APB_TIMEOUT   = 16;
  localparam int POLL_LIMIT    = 32;
  localparam int RESET_TIMEOUT = 32;
  // clk cycles per SCK or TCK level
  localparam int LEVEL_CYCLES  = 8;

  localparam logic [11:0] GPIO_OUT_ADDR  = {`CHIP_APB_SEL_GPIO, `CHIP_GPIO_OUT_OFS};
  localparam logic [11:0] GPIO_OE_ADDR   = {`CHIP_APB_SEL_GPIO, `CHIP_GPIO_OE_OFS};
  localparam logic [11:0] GPIO_IN_ADDR   = {`CHIP_APB_SEL_GPIO, `CHIP_GPIO_IN_OFS};
  localparam logic [11:0] SPI_RXDATA_ADDR = {`CHIP_APB_SEL_SPI, `CHIP_SPI_RXDATA_OFS};
  localparam logic [11:0] SPI_STATUS_ADDR = {`CHIP_APB_SEL_SPI, `CHIP_SPI_STATUS_OFS};
  localparam logic [11:0] SPI_TXDATA_ADDR = {`CHIP_APB_SEL_SPI, `CHIP_SPI_TXDATA_OFS};

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  chip_pkg::apb_addr_t paddr;
  chip_pkg::apb_data_t pwdata;
  chip_pkg::apb_data_t prdata;
  logic                pready;
  logic                pslverr;
  logic                jtag_spi_n;
  logic                dps_sck;
  logic                dps_sdi;
  logic                dps_cs;
  logic                dps_trst_n;
  logic                dps_sdo;
  chip_pkg::gpio_t     gpio_in;
  chip_pkg::gpio_t     gpio_out;
  chip_pkg::gpio_t     gpio_oe;

  int                  errors;
  int                  tests_run;
  int                  tests_failed;
  logic                timed_out;

  // Reference models
  logic [7:0]          rx_model[$];
  chip_pkg::gpio_t     out_img;
  chip_pkg::gpio_t     oe_img;
  logic [7:0]          tx_img;

  clk_rst_gen u_clk_rst_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  chip_top dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .jtag_spi_n_i (jtag_spi_n),
    .dps_sck_i    (dps_sck),
    .dps_sdi_i    (dps_sdi),
    .dps_cs_i     (dps_cs),
    .dps_trst_n_i (dps_trst_n),
    .dps_sdo_o    (dps_sdo),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe)
  );

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%08h exp 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  // One APB transfer with its setup and access cycles
  task automatic apb_access(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    rdata = '0;
    err = 1'b0;
    waited = 0;
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      report_timeout("pready");
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    compare_word("pslverr_o", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    compare_word("pslverr_o", 32'(err), 32'd0);
  endtask

  // Polls STATUS until the FIFO count matches
  task automatic poll_rx_count(input int exp_count);
    logic [31:0] st;
    int          polls;
    polls = 0;
    apb_read(SPI_STATUS_ADDR, st);
    while (st[3:0] != 4'(exp_count) && polls < POLL_LIMIT && !timed_out) begin
      apb_read(SPI_STATUS_ADDR, st);
      polls++;
    end
    if (st[3:0] != 4'(exp_count)) begin
      report_timeout("the RX FIFO count");
    end
  endtask

  task automatic spi_select();
    @(posedge clk);
    dps_sck <= 1'b0;
    dps_cs <= 1'b0;
    idle_cycles(LEVEL_CYCLES);
  endtask

  task automatic spi_deselect();
    @(posedge clk);
    dps_cs <= 1'b1;
    idle_cycles(LEVEL_CYCLES);
  endtask

  // Mode 0 byte transfer MSB first with SDO sampled just before each SCK rise
  task automatic spi_shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      dps_sck <= 1'b0;
      dps_sdi <= tx[i];
      idle_cycles(LEVEL_CYCLES);
      @(negedge clk);
      rx[i] = dps_sdo;
      @(posedge clk);
      dps_sck <= 1'b1;
      idle_cycles(LEVEL_CYCLES);
    end
    @(posedge clk);
    dps_sck <= 1'b0;
    idle_cycles(LEVEL_CYCLES);
  endtask

  // One TCK period with TDO sampled before the rise
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    @(posedge clk);
    dps_sck <= 1'b0;
    dps_cs <= tms;
    dps_sdi <= tdi;
    idle_cycles(LEVEL_CYCLES);
    @(negedge clk);
    tdo = dps_sdo;
    @(posedge clk);
    dps_sck <= 1'b1;
    idle_cycles(LEVEL_CYCLES);
  endtask

  task automatic jtag_reset_to_idle();
    logic tdo;
    for (int i = 0; i < 5; i++) begin
      jtag_clock(1'b1, 1'b0, tdo);
    end
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  // From Run-Test/Idle through Shift-DR and back to Run-Test/Idle
  task automatic jtag_shift_dr(input int n, input logic [31:0] tdi_bits,
                               output logic [31:0] tdo_bits);
    logic tdo;
    tdo_bits = '0;
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    for (int k = 0; k < n; k++) begin
      jtag_clock(k == n - 1, tdi_bits[k], tdo);
      tdo_bits[k] = tdo;
    end
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  task automatic jtag_shift_ir(input logic [3:0] ir, output logic [3:0] captured);
    logic tdo;
    captured = '0;
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    for (int k = 0; k < 4; k++) begin
      jtag_clock(k == 3, ir[k], tdo);
      captured[k] = tdo;
    end
    jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic check_reset_values();
    @(negedge clk);
    compare_word("prdata_o", prdata, 32'd0);
    compare_word("pready_o", 32'(pready), 32'd0);
    compare_word("pslverr_o", 32'(pslverr), 32'd0);
    compare_word("gpio_o", 32'(gpio_out), 32'd0);
    compare_word("gpio_oe_o", 32'(gpio_oe), 32'd0);
    compare_word("dps_sdo_o", 32'(dps_sdo), 32'd0);
  endtask

  task automatic gpio_registers();
    logic [31:0]     rd;
    chip_pkg::gpio_t in_val;
    for (int iter = 0; iter < 4; iter++) begin
      out_img = chip_pkg::gpio_t'($urandom);
      oe_img = chip_pkg::gpio_t'($urandom);
      apb_write(GPIO_OUT_ADDR, 32'(out_img));
      apb_write(GPIO_OE_ADDR, 32'(oe_img));
      @(negedge clk);
      compare_word("gpio_o", 32'(gpio_out), 32'(out_img));
      compare_word("gpio_oe_o", 32'(gpio_oe), 32'(oe_img));
      apb_read(GPIO_OUT_ADDR, rd);
      compare_word("prdata GPIO OUT", rd, 32'(out_img));
      apb_read(GPIO_OE_ADDR, rd);
      compare_word("prdata GPIO OE", rd, 32'(oe_img));
      in_val = chip_pkg::gpio_t'($urandom);
      @(posedge clk);
      gpio_in <= in_val;
      idle_cycles(4);
      apb_read(GPIO_IN_ADDR, rd);
      compare_word("prdata GPIO IN", rd, 32'(in_val));
    end
  endtask

  task automatic spi_receive();
    int          n;
    logic [7:0]  b;
    logic [7:0]  unused_rx;
    logic [31:0] rd;
    n = $urandom_range(4, 1);
    spi_select();
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      rx_model.push_back(b);
      spi_shift_byte(b, unused_rx);
    end
    spi_deselect();
    poll_rx_count(n);
    apb_read(SPI_STATUS_ADDR, rd);
    compare_word("prdata SPI STATUS", rd, 32'(n));
    while (rx_model.size() > 0) begin
      apb_read(SPI_RXDATA_ADDR, rd);
      compare_word("prdata SPI RXDATA", rd, 32'(rx_model.pop_front()));
    end
  endtask

  task automatic spi_overflow();
    logic [7:0]  b;
    logic [7:0]  unused_rx;
    logic [31:0] rd;
    spi_select();
    for (int i = 0; i < 6; i++) begin
      b = 8'($urandom);
      // A full FIFO drops the byte
      if (rx_model.size() < `CHIP_SPI_RX_DEPTH) begin
        rx_model.push_back(b);
      end
      spi_shift_byte(b, unused_rx);
    end
    spi_deselect();
    poll_rx_count(`CHIP_SPI_RX_DEPTH);
    apb_read(SPI_STATUS_ADDR, rd);
    compare_word("prdata SPI STATUS", rd, 32'h100 | 32'(`CHIP_SPI_RX_DEPTH));
    while (rx_model.size() > 0) begin
      apb_read(SPI_RXDATA_ADDR, rd);
      compare_word("prdata SPI RXDATA", rd, 32'(rx_model.pop_front()));
    end
    apb_read(SPI_RXDATA_ADDR, rd);
    compare_word("prdata SPI RXDATA empty", rd, 32'd0);
    apb_read(SPI_STATUS_ADDR, rd);
    compare_word("prdata SPI STATUS", rd, 32'h100);
    apb_write(SPI_STATUS_ADDR, 32'h100);
    apb_read(SPI_STATUS_ADDR, rd);
    compare_word("prdata SPI STATUS", rd, 32'd0);
  endtask

  task automatic spi_transmit();
    logic [7:0]  b;
    logic [7:0]  got;
    logic [31:0] rd;
    tx_img = 8'($urandom);
    apb_write(SPI_TXDATA_ADDR, 32'(tx_img));
    b = 8'($urandom);
    rx_model.push_back(b);
    spi_select();
    spi_shift_byte(b, got);
    spi_deselect();
    compare_word("dps_sdo_o byte", 32'(got), 32'(tx_img));
    poll_rx_count(1);
    apb_read(SPI_RXDATA_ADDR, rd);
    compare_word("prdata SPI RXDATA", rd, 32'(rx_model.pop_front()));
  endtask

  task automatic jtag_idcode_bypass();
    logic [7:0]  unused_rx;
    logic [31:0] tdi_bits;
    logic [31:0] tdo_bits;
    logic [3:0]  captured;
    logic [31:0] rd;
    @(posedge clk);
    jtag_spi_n <= 1'b1;
    idle_cycles(4);
    // SPI-style traffic now lands on the TAP only
    spi_select();
    spi_shift_byte(8'($urandom), unused_rx);
    spi_deselect();
    jtag_reset_to_idle();
    tdi_bits = $urandom;
    jtag_shift_dr(32, tdi_bits, tdo_bits);
    compare_word("dps_sdo_o IDCODE", tdo_bits, `CHIP_JTAG_IDCODE);
    jtag_shift_ir(chip_pkg::IR_BYPASS, captured);
    compare_word("dps_sdo_o IR capture", 32'(captured), 32'h1);
    tdi_bits = $urandom;
    jtag_shift_dr(16, tdi_bits, tdo_bits);
    compare_word("dps_sdo_o BYPASS", 32'(tdo_bits[15:0]), 32'({tdi_bits[14:0], 1'b0}));
    @(posedge clk);
    dps_sck <= 1'b0;
    dps_cs <= 1'b1;
    idle_cycles(4);
    jtag_spi_n <= 1'b0;
    idle_cycles(4);
    apb_read(SPI_STATUS_ADDR, rd);
    compare_word("prdata SPI STATUS", rd, 32'd0);
  endtask

  task automatic unmapped_access();
    logic [3:0]  page;
    logic [31:0] rd;
    logic        err;
    // Writes carry the inverse of each register so a stray hit shows up
    page = 4'($urandom_range(15, 2));
    apb_access(1'b1, {page, `CHIP_GPIO_OUT_OFS}, ~32'(out_img), rd, err);
    compare_word("pslverr_o write", 32'(err), 32'd1);
    page = 4'($urandom_range(15, 2));
    apb_access(1'b1, {page, `CHIP_GPIO_OE_OFS}, ~32'(oe_img), rd, err);
    compare_word("pslverr_o write", 32'(err), 32'd1);
    page = 4'($urandom_range(15, 2));
    apb_access(1'b1, {page, `CHIP_SPI_TXDATA_OFS}, ~32'(tx_img), rd, err);
    compare_word("pslverr_o write", 32'(err), 32'd1);
    page = 4'($urandom_range(15, 2));
    apb_access(1'b0, {page, `CHIP_SPI_TXDATA_OFS}, 32'd0, rd, err);
    compare_word("pslverr_o read", 32'(err), 32'd1);
    compare_word("prdata unmapped", rd, 32'd0);
    apb_read(GPIO_OUT_ADDR, rd);
    compare_word("prdata GPIO OUT", rd, 32'(out_img));
    apb_read(GPIO_OE_ADDR, rd);
    compare_word("prdata GPIO OE", rd, 32'(oe_img));
    apb_read(SPI_TXDATA_ADDR, rd);
    compare_word("prdata SPI TXDATA", rd, 32'(tx_img));
  endtask

  initial begin
    int mark;
    int waited;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    out_img = '0;
    oe_img = '0;
    tx_img = '0;
    void'($urandom(45296));
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    jtag_spi_n = 1'b0;
    dps_sck = 1'b0;
    dps_sdi = 1'b0;
    dps_cs = 1'b1;
    dps_trst_n = 1'b1;
    gpio_in = '0;

    waited = 0;
    while (!rst_n && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      report_timeout("reset release");
    end

    mark = errors;
    check_reset_values();
    end_test("reset_values", mark);
    mark = errors;
    gpio_registers();
    end_test("gpio", mark);
    mark = errors;
    spi_receive();
    end_test("spi_receive", mark);
    mark = errors;
    spi_overflow();
    end_test("spi_overflow", mark);
    mark = errors;
    spi_transmit();
    end_test("spi_transmit", mark);
    mark = errors;
    jtag_idcode_bypass();
    end_test("jtag", mark);
    mark = errors;
    unmapped_access();
    end_test("apb_errors", mark);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/chip_pkg.sv
hw/apb_xbar.sv
hw/gpio.sv
hw/spi_device.sv
hw/jtag_tap.sv
hw/chip_top.sv
verification/clk_rst_gen.sv
verification/tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the chip testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi

exit 0
